/* Bender.yml */
package:
  name: in_switch

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - in_switch_pkg.sv
      - buf_allocator.sv
      - port_ctrl.sv
      - buf_crossbar.sv
      - in_switch.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_in_switch.sv

/* buf_allocator.sv */
`timescale 1ns/10ps
`include "in_switch_config.svh"

module buf_allocator #(
	parameter int BUF_BASE = 0,
	parameter int NUM_BUFS = `IN_SWITCH_NUM_MAIN_BUFS
) (
	input  logic clk,
	input  logic reset,
	input  logic [NUM_BUFS-1:0] buf_empty,
	input  logic [`IN_SWITCH_NUM_PORTS-1:0] alloc_req,
	output logic [`IN_SWITCH_NUM_PORTS-1:0] alloc_grant,
	output in_switch_pkg::buf_id_t alloc_buf
);
	import in_switch_pkg::*;

	localparam int NUM_PORTS = `IN_SWITCH_NUM_PORTS;
	localparam int IDX_W = (NUM_BUFS > 1) ? $clog2(NUM_BUFS) : 1;
	localparam int PTR_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;
	localparam int WAIT_W = $clog2(`IN_SWITCH_ALLOC_WAIT + 1);

	alloc_state_t state;
	alloc_state_t state_next;
	logic [PTR_W-1:0] port_ptr;
	logic [WAIT_W-1:0] wait_cnt;
	logic [IDX_W-1:0] low_idx;
	logic [IDX_W-1:0] sel_idx;
	logic any_empty;
	logic [NUM_PORTS-1:0] grant_next;

	// lowest-index empty buffer, scanned from the top so the lowest wins
	always_comb begin
		low_idx = '0;
		any_empty = 1'b0;
		for (int i = NUM_BUFS - 1; i >= 0; i--) begin
			if (buf_empty[i]) begin
				low_idx = IDX_W'(i);
				any_empty = 1'b1;
			end
		end
	end

	always_comb begin
		state_next = state;
		grant_next = '0;
		case (state)
			ALLOC_LOOKUP: begin
				if (any_empty) begin
					state_next = ALLOC_GRANT;
				end
			end
			ALLOC_GRANT: begin
				// chosen buffer got filled meanwhile, look again
				if (!buf_empty[sel_idx]) begin
					state_next = ALLOC_LOOKUP;
				end else if (alloc_req[port_ptr]) begin
					grant_next[port_ptr] = 1'b1;
					state_next = ALLOC_WAIT;
				end
			end
			ALLOC_WAIT: begin
				if (wait_cnt == WAIT_W'(`IN_SWITCH_ALLOC_WAIT - 1)) begin
					state_next = ALLOC_LOOKUP;
				end
			end
			default: begin
				state_next = ALLOC_LOOKUP;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ALLOC_LOOKUP;
			port_ptr <= '0;
			wait_cnt <= '0;
			alloc_grant <= '0;
		end else begin
			state <= state_next;
			alloc_grant <= grant_next;
			// round robin, one port per grant cycle
			if (state == ALLOC_GRANT) begin
				port_ptr <= (port_ptr == PTR_W'(NUM_PORTS - 1)) ? '0 : port_ptr + 1'b1;
			end
			if (state == ALLOC_WAIT) begin
				wait_cnt <= wait_cnt + 1'b1;
			end else begin
				wait_cnt <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == ALLOC_LOOKUP) begin
			sel_idx <= low_idx;
		end
	end

	assign alloc_buf = buf_id_t'(BUF_BASE) + buf_id_t'(sel_idx);

endmodule

/* buf_crossbar.sv */
`timescale 1ns/10ps
`include "in_switch_config.svh"

module buf_crossbar (
	input  logic clk,
	input  logic reset,
	input  in_switch_pkg::pkt_word_t [`IN_SWITCH_NUM_PORTS-1:0] port_word,
	input  in_switch_pkg::buf_id_t [`IN_SWITCH_NUM_PORTS-1:0] port_buf,
	input  logic [`IN_SWITCH_NUM_PORTS-1:0] port_buf_req,
	input  logic [`IN_SWITCH_NUM_PORTS-1:0] port_xfer,
	output logic [`IN_SWITCH_NUM_PORTS-1:0] port_ack,
	output in_switch_pkg::pkt_word_t [`IN_SWITCH_NUM_BUFS-1:0] pb_word,
	output logic [`IN_SWITCH_NUM_BUFS-1:0] pb_req,
	input  logic [`IN_SWITCH_NUM_BUFS-1:0] pb_ack,
	input  logic [`IN_SWITCH_NUM_BUFS-1:0] pb_empty,
	output logic [`IN_SWITCH_NUM_MAIN_BUFS-1:0] main_empty,
	output logic [`IN_SWITCH_NUM_BYP_BUFS-1:0] byp_empty
);
	import in_switch_pkg::*;

	localparam int NP = `IN_SWITCH_NUM_PORTS;
	localparam int NB = `IN_SWITCH_NUM_BUFS;
	localparam int NM = `IN_SWITCH_NUM_MAIN_BUFS;

	logic [NB-1:0] ack_q;
	logic [NB-1:0] empty_q;
	logic [NB-1:0] req_next;
	logic [NB-1:0] wr_next;
	logic [NB-1:0] wr_q;
	logic [`IN_SWITCH_DATA_W-1:0] data_q [NB];
	logic [`IN_SWITCH_DATA_W-1:0] data_next [NB];
	logic [`IN_SWITCH_ROUTE_W-1:0] route_q [NB];
	logic [`IN_SWITCH_ROUTE_W-1:0] route_next [NB];

	// decode each port onto its buffer
	always_comb begin
		req_next = '0;
		wr_next = '0;
		for (int b = 0; b < NB; b++) begin
			data_next[b] = data_q[b];
			route_next[b] = route_q[b];
			for (int p = 0; p < NP; p++) begin
				if (port_buf_req[p] && port_buf[p] == buf_id_t'(b)) begin
					req_next[b] = 1'b1;
				end
				if (port_xfer[p] && port_buf[p] == buf_id_t'(b)) begin
					data_next[b] = port_word[p].data;
					route_next[b] = port_word[p].route;
					wr_next[b] = port_word[p].wr;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack_q <= '0;
			empty_q <= '0;
			pb_req <= '0;
			wr_q <= '0;
		end else begin
			ack_q <= pb_ack;
			empty_q <= pb_empty;
			pb_req <= req_next;
			// strobe drops on any buffer nobody is feeding
			wr_q <= wr_next;
		end
	end

	always_ff @(posedge clk) begin
		data_q <= data_next;
		route_q <= route_next;
	end

	always_comb begin
		for (int b = 0; b < NB; b++) begin
			pb_word[b].data = data_q[b];
			pb_word[b].route = route_q[b];
			pb_word[b].wr = wr_q[b];
		end
	end

	// ack of the buffer each port holds
	always_comb begin
		for (int p = 0; p < NP; p++) begin
			port_ack[p] = 1'b0;
			for (int b = 0; b < NB; b++) begin
				if (port_buf[p] == buf_id_t'(b)) begin
					port_ack[p] = ack_q[b];
				end
			end
		end
	end

	// a requested buffer is never offered again
	assign main_empty = empty_q[NM-1:0] & ~pb_req[NM-1:0];
	assign byp_empty = empty_q[NB-1:NM] & ~pb_req[NB-1:NM];

endmodule

/* in_switch.f */
+incdir+.
in_switch_pkg.sv
buf_allocator.sv
port_ctrl.sv
buf_crossbar.sv
in_switch.sv
tb_in_switch.sv

/* in_switch.sv */
`timescale 1ns/10ps
`include "in_switch_config.svh"

module in_switch (
	input  logic clk,
	input  logic reset,
	input  in_switch_pkg::pkt_word_t [`IN_SWITCH_NUM_PORTS-1:0] in_word,
	input  logic [`IN_SWITCH_NUM_PORTS-1:0] in_req,
	input  logic [`IN_SWITCH_NUM_PORTS-1:0] in_bypass,
	output logic [`IN_SWITCH_NUM_PORTS-1:0] in_ack,
	output in_switch_pkg::pkt_word_t [`IN_SWITCH_NUM_BUFS-1:0] pb_word,
	output logic [`IN_SWITCH_NUM_BUFS-1:0] pb_req,
	input  logic [`IN_SWITCH_NUM_BUFS-1:0] pb_ack,
	input  logic [`IN_SWITCH_NUM_BUFS-1:0] pb_empty
);
	import in_switch_pkg::*;

	localparam int NP = `IN_SWITCH_NUM_PORTS;

	// allocator side
	logic [NP-1:0] main_req;
	logic [NP-1:0] byp_req;
	logic [NP-1:0] main_grant;
	logic [NP-1:0] byp_grant;
	buf_id_t main_buf;
	buf_id_t byp_buf;
	logic [`IN_SWITCH_NUM_MAIN_BUFS-1:0] main_empty;
	logic [`IN_SWITCH_NUM_BYP_BUFS-1:0] byp_empty;

	// port controller to crossbar
	buf_id_t [NP-1:0] port_buf;
	logic [NP-1:0] port_buf_req;
	logic [NP-1:0] port_xfer;
	logic [NP-1:0] port_ack;

	for (genvar p = 0; p < NP; p++) begin : g_port
		port_ctrl u_port_ctrl (
			.clk(clk),
			.reset(reset),
			.req(in_req[p]),
			.bypass(in_bypass[p]),
			.main_req(main_req[p]),
			.byp_req(byp_req[p]),
			.main_grant(main_grant[p]),
			.byp_grant(byp_grant[p]),
			.main_buf(main_buf),
			.byp_buf(byp_buf),
			.buf_ack(port_ack[p]),
			.buf_id(port_buf[p]),
			.buf_req(port_buf_req[p]),
			.xfer(port_xfer[p]),
			.ack(in_ack[p])
		);
	end

	buf_allocator #(
		.BUF_BASE(0),
		.NUM_BUFS(`IN_SWITCH_NUM_MAIN_BUFS)
	) u_main_alloc (
		.clk(clk),
		.reset(reset),
		.buf_empty(main_empty),
		.alloc_req(main_req),
		.alloc_grant(main_grant),
		.alloc_buf(main_buf)
	);

	// bypass buffers sit right after the main pool
	buf_allocator #(
		.BUF_BASE(`IN_SWITCH_NUM_MAIN_BUFS),
		.NUM_BUFS(`IN_SWITCH_NUM_BYP_BUFS)
	) u_byp_alloc (
		.clk(clk),
		.reset(reset),
		.buf_empty(byp_empty),
		.alloc_req(byp_req),
		.alloc_grant(byp_grant),
		.alloc_buf(byp_buf)
	);

	buf_crossbar u_buf_crossbar (
		.clk(clk),
		.reset(reset),
		.port_word(in_word),
		.port_buf(port_buf),
		.port_buf_req(port_buf_req),
		.port_xfer(port_xfer),
		.port_ack(port_ack),
		.pb_word(pb_word),
		.pb_req(pb_req),
		.pb_ack(pb_ack),
		.pb_empty(pb_empty),
		.main_empty(main_empty),
		.byp_empty(byp_empty)
	);

endmodule

/* in_switch_config.svh */
`ifndef IN_SWITCH_CONFIG_SVH
`define IN_SWITCH_CONFIG_SVH

// receive ports into the switch
`define IN_SWITCH_NUM_PORTS 4

// packet buffer pools
`define IN_SWITCH_NUM_MAIN_BUFS 4
`define IN_SWITCH_NUM_BYP_BUFS 2
`define IN_SWITCH_NUM_BUFS (`IN_SWITCH_NUM_MAIN_BUFS + `IN_SWITCH_NUM_BYP_BUFS)

// word fields
`define IN_SWITCH_DATA_W 64
`define IN_SWITCH_ROUTE_W 24

// idle cycles after each grant, lets the granted buffer show up in pb_req
`define IN_SWITCH_ALLOC_WAIT 2

`endif

/* in_switch_pkg.sv */
`include "in_switch_config.svh"

package in_switch_pkg;

	// one word on a port or a buffer
	typedef struct packed {
		logic [`IN_SWITCH_DATA_W-1:0] data;
		logic [`IN_SWITCH_ROUTE_W-1:0] route;
		logic wr;
	} pkt_word_t;

	// buffer index across both pools, bypass buffers follow the main ones
	typedef logic [$clog2(`IN_SWITCH_NUM_BUFS)-1:0] buf_id_t;

	typedef enum logic [2:0] {
		PORT_IDLE,
		PORT_LOOKUP,
		PORT_REQUEST,
		PORT_TRANSFER,
		PORT_RELEASE
	} port_state_t;

	typedef enum logic [1:0] {
		ALLOC_LOOKUP,
		ALLOC_GRANT,
		ALLOC_WAIT
	} alloc_state_t;

endpackage

/* port_ctrl.sv */
`timescale 1ns/10ps
`include "in_switch_config.svh"

module port_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  logic bypass,
	output logic main_req,
	output logic byp_req,
	input  logic main_grant,
	input  logic byp_grant,
	input  in_switch_pkg::buf_id_t main_buf,
	input  in_switch_pkg::buf_id_t byp_buf,
	input  logic buf_ack,
	output in_switch_pkg::buf_id_t buf_id,
	output logic buf_req,
	output logic xfer,
	output logic ack
);
	import in_switch_pkg::*;

	port_state_t state;
	port_state_t state_next;
	logic req_q;
	logic byp_sel;
	logic granted;

	// grant from the pool this packet asked
	assign granted = byp_sel ? byp_grant : main_grant;

	assign main_req = (state == PORT_LOOKUP) && !byp_sel;
	assign byp_req = (state == PORT_LOOKUP) && byp_sel;

	// buffer held from grant until the sender lets go
	assign buf_req = (state == PORT_REQUEST) || (state == PORT_TRANSFER);

	// words are taken while the port sees ack
	assign xfer = ack;

	always_comb begin
		state_next = state;
		case (state)
			PORT_IDLE: begin
				if (req_q) begin
					state_next = PORT_LOOKUP;
				end
			end
			PORT_LOOKUP: begin
				if (granted) begin
					state_next = PORT_REQUEST;
				end
			end
			PORT_REQUEST: begin
				if (buf_ack) begin
					state_next = PORT_TRANSFER;
				end
			end
			PORT_TRANSFER: begin
				if (!req_q) begin
					state_next = PORT_RELEASE;
				end
			end
			PORT_RELEASE: begin
				if (!buf_ack) begin
					state_next = PORT_IDLE;
				end
			end
			default: begin
				state_next = PORT_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= PORT_IDLE;
			req_q <= 1'b0;
			byp_sel <= 1'b0;
			ack <= 1'b0;
		end else begin
			state <= state_next;
			req_q <= req;
			// pool choice is fixed for the whole packet
			if (state == PORT_IDLE && req_q) begin
				byp_sel <= bypass;
			end
			if (state == PORT_REQUEST && buf_ack) begin
				ack <= 1'b1;
			end else if (state == PORT_RELEASE && !buf_ack) begin
				ack <= 1'b0;
			end
		end
	end

	// granted buffer index
	always_ff @(posedge clk) begin
		if (state == PORT_LOOKUP && granted) begin
			buf_id <= byp_sel ? byp_buf : main_buf;
		end
	end

endmodule

/* tb_in_switch.sv */
`timescale 1ns/10ps
`include "in_switch_config.svh"

module tb_in_switch;
	import in_switch_pkg::*;

	localparam int NP = `IN_SWITCH_NUM_PORTS;
	localparam int NB = `IN_SWITCH_NUM_BUFS;
	localparam int NM = `IN_SWITCH_NUM_MAIN_BUFS;
	localparam int RW = `IN_SWITCH_ROUTE_W;
	localparam int TIMEOUT = 300;

	logic clk;
	logic reset;
	pkt_word_t [NP-1:0] in_word;
	logic [NP-1:0] in_req;
	logic [NP-1:0] in_bypass;
	logic [NP-1:0] in_ack;
	pkt_word_t [NB-1:0] pb_word;
	logic [NB-1:0] pb_req;
	logic [NB-1:0] pb_ack;
	logic [NB-1:0] pb_empty;

	logic [15:0] lfsr;
	logic [NB-1:0] hold_full;
	int ack_delay [NB];
	// monitor state per port
	logic [NP-1:0] sent_valid;
	pkt_word_t sent_word [NP];
	logic [NP-1:0] ack_prev;
	int srv [NP];
	int last_srv [NP];

	in_switch u_in_switch (
		.clk(clk),
		.reset(reset),
		.in_word(in_word),
		.in_req(in_req),
		.in_bypass(in_bypass),
		.in_ack(in_ack),
		.pb_word(pb_word),
		.pb_req(pb_req),
		.pb_ack(pb_ack),
		.pb_empty(pb_empty)
	);

	always #20 clk = ~clk;

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		$display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
		abort_run();
	endtask

	task automatic report_error(input string what);
		$display("ERROR: %s", what);
		abort_run();
	endtask

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hB400 : 16'h0000);
		end
		return v;
	endfunction

	// buffer models ack a few cycles after pb_req and go empty after release
	always @(posedge clk) begin : buffers
		#1;
		for (int b = 0; b < NB; b++) begin
			if (reset) begin
				pb_ack[b] = 1'b0;
				pb_empty[b] = 1'b1;
				ack_delay[b] = 1 + b % 3;
			end else if (pb_req[b] && !pb_ack[b]) begin
				pb_empty[b] = 1'b0;
				if (ack_delay[b] == 0) begin
					pb_ack[b] = 1'b1;
				end else begin
					ack_delay[b]--;
				end
			end else if (!pb_req[b] && pb_ack[b]) begin
				pb_ack[b] = 1'b0;
			end else if (!pb_req[b]) begin
				pb_empty[b] = !hold_full[b];
				ack_delay[b] = 1 + b % 3;
			end
		end
	end

	// one packet on one port with the first word always written
	task automatic send_packet(input int p, input logic byp, input int len);
		int t;
		int n;
		logic wr;
		@(posedge clk);
		#2;
		in_bypass[p] = byp;
		in_word[p] = '0;
		in_req[p] = 1'b1;
		t = 0;
		while (!in_ack[p]) begin
			@(posedge clk);
			#2;
			t++;
			assert (t < TIMEOUT) else report_error($sformatf("port %0d never got in_ack", p));
		end
		n = 0;
		while (n < len) begin
			wr = (n == 0) || (rand_bits(2) != 0);
			in_word[p].data = {rand_bits(32), rand_bits(32)};
			in_word[p].route = {8'(p), 16'(n)};
			in_word[p].wr = wr;
			if (wr) begin
				n++;
			end
			@(posedge clk);
			#2;
		end
		in_word[p].wr = 1'b0;
		in_req[p] = 1'b0;
		t = 0;
		while (in_ack[p]) begin
			@(posedge clk);
			#2;
			t++;
			assert (t < TIMEOUT) else report_error($sformatf("port %0d in_ack stuck high", p));
		end
		in_bypass[p] = 1'b0;
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin : monitor
		int hits [NP];
		int p;
		if (reset) begin
			for (int i = 0; i < NP; i++) begin
				srv[i] = -1;
				sent_valid[i] = 1'b0;
				ack_prev[i] = 1'b0;
			end
		end else begin
			for (int i = 0; i < NP; i++) begin
				hits[i] = 0;
			end
			// words sent last cycle land on the serving buffer now
			for (int b = 0; b < NB; b++) begin
				if (pb_word[b].wr === 1'b1) begin
					p = int'(pb_word[b].route[RW-1 -: 8]);
					assert (p < NP) else
						report_error($sformatf("buffer %0d got a bad route", b));
					assert (sent_valid[p]) else
						report_error($sformatf("buffer %0d strobed an unsent word", b));
					assert (pb_word[b] === sent_word[p]) else
						mismatch($sformatf("pb_word[%0d]", b), pb_word[b], sent_word[p]);
					assert (pb_req[b]) else
						mismatch($sformatf("pb_req[%0d]", b), pb_req[b], 1);
					if (srv[p] < 0) begin
						srv[p] = b;
						assert ((b >= NM) == in_bypass[p]) else
							report_error($sformatf(
								"port %0d with in_bypass %0b served by buffer %0d",
								p, in_bypass[p], b));
					end
					assert (srv[p] == b) else
						mismatch($sformatf("port %0d buffer", p), b, srv[p]);
					hits[p]++;
				end
			end
			for (int i = 0; i < NP; i++) begin
				assert (hits[i] == (sent_valid[i] ? 1 : 0)) else
					mismatch($sformatf("port %0d word count", i), hits[i], sent_valid[i]);
				if (ack_prev[i] && !in_ack[i]) begin
					assert (!in_req[i]) else
						report_error($sformatf("port %0d lost in_ack mid packet", i));
					assert (srv[i] >= 0) else
						report_error($sformatf("port %0d ended with no word seen", i));
					assert (!pb_req[srv[i]]) else
						mismatch($sformatf("pb_req[%0d]", srv[i]), pb_req[srv[i]], 0);
					assert (!pb_ack[srv[i]]) else
						mismatch($sformatf("pb_ack[%0d]", srv[i]), pb_ack[srv[i]], 0);
					last_srv[i] = srv[i];
					srv[i] = -1;
				end
				// a held buffer keeps its request while the sender holds in_req
				if (srv[i] >= 0 && in_req[i]) begin
					assert (pb_req[srv[i]]) else
						mismatch($sformatf("pb_req[%0d]", srv[i]), pb_req[srv[i]], 1);
				end
				for (int j = i + 1; j < NP; j++) begin
					if (srv[i] >= 0 && srv[j] >= 0) begin
						assert (srv[i] != srv[j]) else report_error("two ports share one buffer");
					end
				end
				ack_prev[i] = in_ack[i];
			end
			assert ($countones(pb_req) <= $countones(in_req | in_ack)) else
				report_error($sformatf("pb_req 0x%0h exceeds active ports 0x%0h",
					pb_req, in_req | in_ack));
			for (int i = 0; i < NP; i++) begin
				sent_valid[i] = in_ack[i] && in_word[i].wr;
				sent_word[i] = in_word[i];
			end
		end
	end

	initial begin : stimulus
		logic [NP-1:0] byp;
		int len [NP];
		clk = 1'b0;
		reset = 1'b1;
		in_word = '0;
		in_req = '0;
		in_bypass = '0;
		pb_ack = '0;
		pb_empty = '1;
		hold_full = '0;
		lfsr = 16'd47;
		for (int i = 0; i < NP; i++) begin
			last_srv[i] = -1;
		end
		repeat (5) @(posedge clk);
		#2;
		reset = 1'b0;
		@(negedge clk);
		assert (in_ack == '0) else mismatch("in_ack", in_ack, 0);
		assert (pb_req == '0) else mismatch("pb_req", pb_req, 0);
		for (int b = 0; b < NB; b++) begin
			assert (pb_word[b].wr == 1'b0) else
				mismatch($sformatf("pb_word[%0d].wr", b), pb_word[b].wr, 0);
		end
		// one port at a time
		for (int i = 0; i < 8; i++) begin
			send_packet(i % NP, 1'(rand_bits(1)), int'(rand_bits(3)) + 1);
		end
		// lowest empty main buffer
		hold_full = 6'b000011;
		repeat (4) @(posedge clk);
		send_packet(2, 1'b0, 3);
		// serving buffer is recorded at the in_ack fall
		@(posedge clk);
		#2;
		assert (last_srv[2] == 2) else mismatch("port 2 buffer", last_srv[2], 2);
		hold_full = '0;
		// all ports at once with the first round all bypass
		for (int r = 0; r < 4; r++) begin
			for (int i = 0; i < NP; i++) begin
				byp[i] = (r == 0) ? 1'b1 : 1'(rand_bits(1));
				len[i] = int'(rand_bits(3)) + 1;
			end
			fork
				send_packet(0, byp[0], len[0]);
				send_packet(1, byp[1], len[1]);
				send_packet(2, byp[2], len[2]);
				send_packet(3, byp[3], len[3]);
			join
		end
		repeat (2) @(posedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
